// ==== source/tl_mon_config.svh ====
//////////////////////////////
// TL-UL monitor configuration.
// Bus widths and the largest legal transfer size.
//////////////////////////////

`ifndef TL_MON_CONFIG_SVH
`define TL_MON_CONFIG_SVH

// Data bus width in bits.
`define TL_DATA_WIDTH 32

// One mask bit per byte lane.
`define TL_MASK_WIDTH (`TL_DATA_WIDTH / 8)

// Address width in bits.
`define TL_ADDR_WIDTH 32

// Source ID width, one pending entry per ID.
`define TL_SOURCE_WIDTH 3

// Size field holds log2 of the byte count.
`define TL_SIZE_WIDTH 2

// Largest legal size, equal to the bus width in TL-UL.
`define TL_MAX_SIZE 2

`endif

// ==== source/tl_mon_pkg.sv ====
//////////////////////////////
// TL-UL monitor types.
// Opcodes, violation bits and pending entries.
//////////////////////////////

`include "tl_mon_config.svh"

package tl_mon_pkg;

  // A channel request opcodes.
  // Encodings 2, 3, 5, 6 and 7 are not TL-UL requests.
  typedef enum logic [2:0] {
    PutFullData    = 3'h0,
    PutPartialData = 3'h1,
    Get            = 3'h4
  } tl_a_op_e;

  // D channel response opcodes.
  typedef enum logic [2:0] {
    AccessAck     = 3'h0,
    AccessAckData = 3'h1
  } tl_d_op_e;

  //////////////////////////////
  // Violation reporting
  //////////////////////////////

  // Bit positions in the violation vector.
  // A channel rules first, then D channel rules.
  typedef enum int unsigned {
    A_OPCODE         = 0,
    A_PARAM          = 1,
    A_SIZE           = 2,
    A_MASK           = 3,
    A_ALIGN          = 4,
    A_CORRUPT        = 5,
    A_SOURCE_BUSY    = 6,
    D_OPCODE         = 7,
    D_NO_REQ         = 8,
    D_MISMATCH       = 9,
    D_PARAM          = 10,
    D_DENIED_CORRUPT = 11
  } viol_idx_e;

  // Number of rules in the vector.
  localparam int unsigned ViolCount = 12;

  // One flag per rule, indexed by viol_idx_e.
  typedef logic [ViolCount-1:0] viol_vec_t;

  //////////////////////////////
  // Outstanding requests
  //////////////////////////////

  // What a response is checked against.
  typedef struct packed {
    logic                      pend;
    tl_a_op_e                  opcode;
    logic [`TL_SIZE_WIDTH-1:0] size;
  } pend_entry_t;

endpackage

// ==== source/tl_a_if.sv ====
//////////////////////////////
// TL-UL A channel beat bundle.
//////////////////////////////

`timescale 1ns/1ps

`include "tl_mon_config.svh"

interface tl_a_if;

  logic                        valid;
  logic                        ready;
  logic [2:0]                  opcode;
  logic [2:0]                  param;
  logic [`TL_SIZE_WIDTH-1:0]   size;
  logic [`TL_SOURCE_WIDTH-1:0] source;
  logic [`TL_ADDR_WIDTH-1:0]   address;
  logic [`TL_MASK_WIDTH-1:0]   mask;
  logic                        corrupt;

  // Beat accepted at this edge.
  // Every consumer takes the handshake from here.
  logic fire;

  assign fire = valid & ready;

  // Filled from the observed port.
  modport mon (output valid, ready, opcode, param, size, source, address, mask, corrupt);

  // Read side for checkers and the table.
  modport rx (input valid, ready, opcode, param, size, source, address, mask, corrupt, fire);

endinterface

// ==== source/tl_d_if.sv ====
//////////////////////////////
// TL-UL D channel beat bundle.
//////////////////////////////

`timescale 1ns/1ps

`include "tl_mon_config.svh"

interface tl_d_if;

  logic                        valid;
  logic                        ready;
  logic [2:0]                  opcode;
  logic [1:0]                  param;
  logic [`TL_SIZE_WIDTH-1:0]   size;
  logic [`TL_SOURCE_WIDTH-1:0] source;
  logic                        denied;
  logic                        corrupt;

  // Response accepted at this edge.
  logic fire;

  assign fire = valid & ready;

  // Filled from the observed port.
  modport mon (output valid, ready, opcode, param, size, source, denied, corrupt);

  // Read side for the checker and the table.
  modport rx (input valid, ready, opcode, param, size, source, denied, corrupt, fire);

endinterface

// ==== source/tl_a_checker.sv ====
//////////////////////////////
// TL-UL A channel checker.
// Field legality of each accepted request beat.
//////////////////////////////

`timescale 1ns/1ps

`include "tl_mon_config.svh"

module tl_a_checker (
  tl_a_if.rx                    a,
  output tl_mon_pkg::viol_vec_t a_viol
);

  localparam int unsigned MaskW = `TL_MASK_WIDTH;
  localparam int unsigned OffW  = $clog2(MaskW);
  // Wide enough for 2**size at the largest encodable size.
  localparam int unsigned LenW  = 1 << `TL_SIZE_WIDTH;
  // Lane window before truncation, largest length plus largest offset.
  localparam int unsigned WinW  = (1 << (LenW - 1)) + MaskW;

  logic                      op_legal;
  logic [LenW-1:0]           size_bytes;
  logic [LenW-1:0]           mask_cnt;
  logic                      mask_contig;
  logic [`TL_ADDR_WIDTH-1:0] addr_low;
  logic [WinW-1:0]           window_wide;
  logic [MaskW-1:0]          window;

  assign op_legal = a.opcode inside {tl_mon_pkg::PutFullData, tl_mon_pkg::PutPartialData,
                                     tl_mon_pkg::Get};

  // Bytes covered by the request.
  assign size_bytes = LenW'(1) << a.size;
  assign mask_cnt   = LenW'($countones(a.mask));

  // At most one rising and one falling edge across the lanes.
  assign mask_contig = $countones(a.mask ^ {a.mask[MaskW-2:0], 1'b0}) <= 2;

  // Address bits below the transfer size.
  assign addr_low = a.address & `TL_ADDR_WIDTH'(size_bytes - LenW'(1));

  // Lanes the transfer may touch, starting at the byte offset.
  assign window_wide = ((WinW'(1) << size_bytes) - WinW'(1)) << a.address[OffW-1:0];
  assign window      = window_wide[MaskW-1:0];

  always_comb begin
    a_viol = '0;
    if (a.fire) begin
      if (!op_legal) begin
        // Content rules depend on the opcode, so report only this one.
        a_viol[tl_mon_pkg::A_OPCODE] = 1'b1;
      end else begin
        a_viol[tl_mon_pkg::A_PARAM] = (a.param != '0);
        a_viol[tl_mon_pkg::A_SIZE]  = (a.size > `TL_SIZE_WIDTH'(`TL_MAX_SIZE));

        // Count limit, exact count for full puts, no gaps for Get and full puts.
        a_viol[tl_mon_pkg::A_MASK] =
            (mask_cnt > size_bytes) ||
            ((a.opcode == tl_mon_pkg::PutFullData) && (mask_cnt != size_bytes)) ||
            ((a.opcode inside {tl_mon_pkg::Get, tl_mon_pkg::PutFullData}) && !mask_contig);

        // Misaligned address, or lanes outside the sized window.
        a_viol[tl_mon_pkg::A_ALIGN] = (addr_low != '0) || ((a.mask & ~window) != '0);

        // Get carries no payload that could be corrupt.
        a_viol[tl_mon_pkg::A_CORRUPT] = (a.opcode == tl_mon_pkg::Get) && a.corrupt;
      end
    end
  end

endmodule

// ==== source/tl_pending_table.sv ====
//////////////////////////////
// Outstanding request table.
// One entry per source ID, with the busy-source check.
//////////////////////////////

`timescale 1ns/1ps

`include "tl_mon_config.svh"

module tl_pending_table (
  input  logic                    clk_i,
  input  logic                    rst_ni,
  tl_a_if.rx                      a,
  tl_d_if.rx                      d,
  output tl_mon_pkg::pend_entry_t d_entry,
  output logic                    a_busy
);

  localparam int unsigned NumSrc = 1 << `TL_SOURCE_WIDTH;

  tl_mon_pkg::pend_entry_t entries_q [NumSrc];

  logic a_legal;
  logic d_legal;
  logic d_clear;
  logic same_src;
  logic a_write;

  assign a_legal = a.opcode inside {tl_mon_pkg::PutFullData, tl_mon_pkg::PutPartialData,
                                    tl_mon_pkg::Get};
  assign d_legal = d.opcode inside {tl_mon_pkg::AccessAck, tl_mon_pkg::AccessAckData};

  // Lookup for the D checker, state before this edge.
  assign d_entry = entries_q[d.source];

  // Responses with a bad opcode leave the table alone.
  assign d_clear  = d.fire && d_legal;
  assign same_src = (d.source == a.source);

  // A response retiring the same source frees it for this request.
  assign a_busy  = a.fire && a_legal && entries_q[a.source].pend && !(d_clear && same_src);
  assign a_write = a.fire && a_legal && !a_busy;

  //////////////////////////////
  // Entry update
  //////////////////////////////

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      for (int i = 0; i < NumSrc; i++) begin
        entries_q[i] <= '0;
      end
    end else begin
      // Retire first.
      if (d_clear) begin
        entries_q[d.source].pend <= 1'b0;
      end
      // A new request wins over a retire on the same source.
      // A busy source keeps its first request.
      if (a_write) begin
        entries_q[a.source].pend   <= 1'b1;
        entries_q[a.source].opcode <= tl_mon_pkg::tl_a_op_e'(a.opcode);
        entries_q[a.source].size   <= a.size;
      end
    end
  end

endmodule

// ==== source/tl_d_checker.sv ====
//////////////////////////////
// TL-UL D channel checker.
// Response rules against the pending request.
//////////////////////////////

`timescale 1ns/1ps

module tl_d_checker (
  tl_d_if.rx                      d,
  input  tl_mon_pkg::pend_entry_t d_entry,
  output tl_mon_pkg::viol_vec_t   d_viol
);

  logic op_legal;
  logic is_ack;
  logic is_ack_data;
  logic req_is_put;
  logic req_is_get;
  logic op_mismatch;

  assign is_ack      = (d.opcode == tl_mon_pkg::AccessAck);
  assign is_ack_data = (d.opcode == tl_mon_pkg::AccessAckData);
  assign op_legal    = is_ack || is_ack_data;

  // Kind of the stored request.
  assign req_is_get = (d_entry.opcode == tl_mon_pkg::Get);
  assign req_is_put = d_entry.opcode inside {tl_mon_pkg::PutFullData,
                                             tl_mon_pkg::PutPartialData};

  // Data comes back only for Get, a plain ack only for puts.
  assign op_mismatch = (is_ack_data && !req_is_get) || (is_ack && !req_is_put);

  always_comb begin
    d_viol = '0;
    if (d.fire) begin
      if (!op_legal) begin
        d_viol[tl_mon_pkg::D_OPCODE] = 1'b1;
      end else begin
        if (!d_entry.pend) begin
          // Nothing to compare against.
          d_viol[tl_mon_pkg::D_NO_REQ] = 1'b1;
        end else begin
          d_viol[tl_mon_pkg::D_MISMATCH] = op_mismatch || (d.size != d_entry.size);
        end

        d_viol[tl_mon_pkg::D_PARAM] = (d.param != '0);

        // Plain ack has no payload to corrupt.
        // A denied read must mark its data corrupt.
        d_viol[tl_mon_pkg::D_DENIED_CORRUPT] = (is_ack && d.corrupt) ||
                                               (is_ack_data && d.denied && !d.corrupt);
      end
    end
  end

endmodule

// ==== source/tl_ul_monitor.sv ====
//////////////////////////////
// TL-UL passive port monitor.
// Registers rule violations one cycle after the beat.
//////////////////////////////

`timescale 1ns/1ps

`include "tl_mon_config.svh"

module tl_ul_monitor (
  input  logic                        clk_i,
  input  logic                        rst_ni,
  // A channel.
  input  logic                        a_valid,
  input  logic                        a_ready,
  input  logic [2:0]                  a_opcode,
  input  logic [2:0]                  a_param,
  input  logic [`TL_SIZE_WIDTH-1:0]   a_size,
  input  logic [`TL_SOURCE_WIDTH-1:0] a_source,
  input  logic [`TL_ADDR_WIDTH-1:0]   a_address,
  input  logic [`TL_MASK_WIDTH-1:0]   a_mask,
  input  logic                        a_corrupt,
  // D channel.
  input  logic                        d_valid,
  input  logic                        d_ready,
  input  logic [2:0]                  d_opcode,
  input  logic [1:0]                  d_param,
  input  logic [`TL_SIZE_WIDTH-1:0]   d_size,
  input  logic [`TL_SOURCE_WIDTH-1:0] d_source,
  input  logic                        d_denied,
  input  logic                        d_corrupt,
  // Report.
  output logic                        viol_valid,
  output tl_mon_pkg::viol_vec_t       viol_flags,
  output logic                        viol_sticky
);

  tl_a_if a_bus ();
  tl_d_if d_bus ();

  tl_mon_pkg::viol_vec_t   a_viol;
  tl_mon_pkg::viol_vec_t   d_viol;
  tl_mon_pkg::viol_vec_t   busy_vec;
  tl_mon_pkg::viol_vec_t   viol_d;
  tl_mon_pkg::pend_entry_t d_entry;
  logic                    a_busy;

  //////////////////////////////
  // Bundle wiring
  //////////////////////////////

  // Observed port into the bundles, nothing is driven back.
  assign a_bus.valid   = a_valid;
  assign a_bus.ready   = a_ready;
  assign a_bus.opcode  = a_opcode;
  assign a_bus.param   = a_param;
  assign a_bus.size    = a_size;
  assign a_bus.source  = a_source;
  assign a_bus.address = a_address;
  assign a_bus.mask    = a_mask;
  assign a_bus.corrupt = a_corrupt;

  assign d_bus.valid   = d_valid;
  assign d_bus.ready   = d_ready;
  assign d_bus.opcode  = d_opcode;
  assign d_bus.param   = d_param;
  assign d_bus.size    = d_size;
  assign d_bus.source  = d_source;
  assign d_bus.denied  = d_denied;
  assign d_bus.corrupt = d_corrupt;

  tl_a_checker tl_a_checker_inst (
    .a      (a_bus),
    .a_viol (a_viol)
  );

  tl_pending_table tl_pending_table_inst (
    .clk_i   (clk_i),
    .rst_ni  (rst_ni),
    .a       (a_bus),
    .d       (d_bus),
    .d_entry (d_entry),
    .a_busy  (a_busy)
  );

  tl_d_checker tl_d_checker_inst (
    .d       (d_bus),
    .d_entry (d_entry),
    .d_viol  (d_viol)
  );

  //////////////////////////////
  // Report register
  //////////////////////////////

  always_comb begin
    busy_vec = '0;
    busy_vec[tl_mon_pkg::A_SOURCE_BUSY] = a_busy;
  end

  // Both channels can flag in the same cycle.
  assign viol_d = a_viol | d_viol | busy_vec;

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      viol_flags  <= '0;
      viol_sticky <= 1'b0;
    end else begin
      viol_flags  <= viol_d;
      // Rises together with the first viol_valid.
      viol_sticky <= viol_sticky | (|viol_d);
    end
  end

  // Follows the registered vector, no extra state.
  assign viol_valid = |viol_flags;

endmodule

// ==== verification/tl_ul_monitor_properties.sv ====
//////////////////////////////
// TL-UL monitor report properties.
// Bound to the monitor to watch the report outputs.
//////////////////////////////

`timescale 1ns/1ps

module tl_ul_monitor_properties (
  input logic                  clk_i,
  input logic                  rst_ni,
  input logic                  a_valid,
  input logic                  a_ready,
  input logic                  d_valid,
  input logic                  d_ready,
  input logic                  viol_valid,
  input tl_mon_pkg::viol_vec_t viol_flags,
  input logic                  viol_sticky
);

  // Number of failed properties.
  int unsigned prop_fails = 0;

  // Report comes out of reset clear.
  reset_clear: assert property (@(posedge clk_i) $rose(rst_ni) |-> !viol_valid && !viol_sticky)
    else begin
      prop_fails++;
      $error("report not clear after reset");
    end

  // Valid is exactly a nonzero vector.
  valid_is_any: assert property (@(posedge clk_i) disable iff (!rst_ni)
    viol_valid == (viol_flags != '0))
    else begin
      prop_fails++;
      $error("viol_valid does not follow viol_flags");
    end

  // Sticky holds until reset.
  sticky_holds: assert property (@(posedge clk_i) disable iff (!rst_ni)
    viol_sticky |=> viol_sticky)
    else begin
      prop_fails++;
      $error("viol_sticky fell without reset");
    end

  // Flags only after an accepted beat.
  flags_need_fire: assert property (@(posedge clk_i) disable iff (!rst_ni)
    (viol_flags != '0) |-> $past((a_valid && a_ready) || (d_valid && d_ready)))
    else begin
      prop_fails++;
      $error("flags raised without a beat");
    end

endmodule

// ==== verification/tl_ul_monitor_tb.sv ====
//////////////////////////////
// TL-UL monitor testbench.
// Directed and random traffic against a reference model.
//////////////////////////////

`timescale 1ns/1ps

`include "tl_mon_config.svh"

module tl_ul_monitor_tb;

  localparam int unsigned MaskW     = `TL_MASK_WIDTH;
  localparam int unsigned WaitLimit = 64;

  logic                        clk_i;
  logic                        rst_ni;
  logic                        a_valid, a_ready, a_corrupt;
  logic [2:0]                  a_opcode, a_param;
  logic [`TL_SIZE_WIDTH-1:0]   a_size;
  logic [`TL_SOURCE_WIDTH-1:0] a_source;
  logic [`TL_ADDR_WIDTH-1:0]   a_address;
  logic [MaskW-1:0]            a_mask;
  logic                        d_valid, d_ready, d_denied, d_corrupt;
  logic [2:0]                  d_opcode;
  logic [1:0]                  d_param;
  logic [`TL_SIZE_WIDTH-1:0]   d_size;
  logic [`TL_SOURCE_WIDTH-1:0] d_source;
  logic                        viol_valid, viol_sticky;
  tl_mon_pkg::viol_vec_t       viol_flags;

  // Reference model state.
  logic [(1<<`TL_SOURCE_WIDTH)-1:0] pend_m;
  logic [2:0]                       op_m   [1<<`TL_SOURCE_WIDTH];
  logic [`TL_SIZE_WIDTH-1:0]        size_m [1<<`TL_SOURCE_WIDTH];
  tl_mon_pkg::viol_vec_t            exp_flags;
  logic                             exp_sticky;
  logic                             stall_en;
  int unsigned                      errors;

  tl_ul_monitor tl_ul_monitor_inst (.*);

  bind tl_ul_monitor tl_ul_monitor_properties tl_ul_monitor_properties_inst (.*);

  always #4 clk_i = ~clk_i;

  function automatic logic legal_a_op(input logic [2:0] op);
    return op inside {tl_mon_pkg::PutFullData, tl_mon_pkg::PutPartialData, tl_mon_pkg::Get};
  endfunction

  //////////////////////////////
  // Reference model
  //////////////////////////////

  // Expected vector for the beats present at this edge.
  function automatic tl_mon_pkg::viol_vec_t ref_flags();
    tl_mon_pkg::viol_vec_t v;
    int unsigned bytes, cnt, off, lo, hi;
    logic gap, outside, d_ack, d_data, d_clear;
    v = '0;
    bytes = 1 << a_size;
    cnt = $countones(a_mask);
    off = a_address % MaskW;
    lo = MaskW;
    hi = 0;
    outside = 1'b0;
    // First and last lane in use, and any lane past the sized window.
    for (int i = 0; i < MaskW; i++) begin
      if (a_mask[i]) begin
        lo = (lo == MaskW) ? i : lo;
        hi = i;
        outside |= (i < off) || (i >= off + bytes);
      end
    end
    gap = (cnt != 0) && (hi - lo + 1 != cnt);
    d_ack = (d_opcode == tl_mon_pkg::AccessAck);
    d_data = (d_opcode == tl_mon_pkg::AccessAckData);
    d_clear = d_valid && d_ready && (d_ack || d_data);
    if (a_valid && a_ready) begin
      if (!legal_a_op(a_opcode)) begin
        v[tl_mon_pkg::A_OPCODE] = 1'b1;
      end else begin
        v[tl_mon_pkg::A_PARAM] = (a_param != 0);
        v[tl_mon_pkg::A_SIZE] = (a_size > `TL_MAX_SIZE);
        v[tl_mon_pkg::A_MASK] = (cnt > bytes) ||
            ((a_opcode == tl_mon_pkg::PutFullData) && (cnt != bytes)) ||
            ((a_opcode != tl_mon_pkg::PutPartialData) && gap);
        v[tl_mon_pkg::A_ALIGN] = (a_address % bytes != 0) || outside;
        v[tl_mon_pkg::A_CORRUPT] = (a_opcode == tl_mon_pkg::Get) && a_corrupt;
        v[tl_mon_pkg::A_SOURCE_BUSY] = pend_m[a_source] && !(d_clear && d_source == a_source);
      end
    end
    if (d_valid && d_ready) begin
      if (!(d_ack || d_data)) begin
        v[tl_mon_pkg::D_OPCODE] = 1'b1;
      end else begin
        v[tl_mon_pkg::D_NO_REQ] = !pend_m[d_source];
        // Data answers Get only, and the size must echo the request.
        v[tl_mon_pkg::D_MISMATCH] = pend_m[d_source] &&
            ((d_data != (op_m[d_source] == tl_mon_pkg::Get)) || (d_size != size_m[d_source]));
        v[tl_mon_pkg::D_PARAM] = (d_param != 0);
        v[tl_mon_pkg::D_DENIED_CORRUPT] = d_ack ? d_corrupt : (d_denied && !d_corrupt);
      end
    end
    return v;
  endfunction

  always @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      exp_flags = '0;
      exp_sticky = 1'b0;
      pend_m = '0;
    end else begin
      exp_flags = ref_flags();
      exp_sticky |= (exp_flags != '0);
      // Retire first, then a request that is not busy takes the entry.
      if (d_valid && d_ready && (d_opcode inside {tl_mon_pkg::AccessAck,
                                                 tl_mon_pkg::AccessAckData})) begin
        pend_m[d_source] = 1'b0;
      end
      if (a_valid && a_ready && legal_a_op(a_opcode) &&
          !exp_flags[tl_mon_pkg::A_SOURCE_BUSY]) begin
        pend_m[a_source] = 1'b1;
        op_m[a_source] = a_opcode;
        size_m[a_source] = a_size;
      end
    end
  end

  // Outputs are settled at the falling edge.
  always @(negedge clk_i) begin
    assert (viol_flags === exp_flags) else begin
      errors++;
      $display("[FAIL] %0t viol_flags expected %h actual %h", $time, exp_flags, viol_flags);
    end
    assert (viol_valid === (exp_flags != '0)) else begin
      errors++;
      $display("[FAIL] %0t viol_valid expected %b actual %b", $time, exp_flags != '0,
               viol_valid);
    end
    assert (viol_sticky === exp_sticky) else begin
      errors++;
      $display("[FAIL] %0t viol_sticky expected %b actual %b", $time, exp_sticky, viol_sticky);
    end
  end

  //////////////////////////////
  // Stimulus
  //////////////////////////////

  task automatic abort_run(input string what);
    $display("timeout: %s", what);
    $display("test failed");
    $finish;
  endtask

  // Drives one request beat and holds it under random stalls until accepted.
  task automatic send_a(input logic [2:0] op, input logic [2:0] param,
                        input logic [`TL_SIZE_WIDTH-1:0] size,
                        input logic [`TL_SOURCE_WIDTH-1:0] src,
                        input logic [`TL_ADDR_WIDTH-1:0] addr,
                        input logic [MaskW-1:0] mask, input logic corrupt);
    int unsigned tries;
    logic rdy;
    tries = 0;
    {a_opcode, a_param, a_size, a_source, a_address, a_mask, a_corrupt} <=
        {op, param, size, src, addr, mask, corrupt};
    a_valid <= 1'b1;
    do begin
      rdy = stall_en ? 1'($urandom_range(0, 1)) : 1'b1;
      a_ready <= rdy;
      @(posedge clk_i);
      tries++;
      if (tries > WaitLimit) abort_run("request beat was never accepted");
    end while (!rdy);
    a_valid <= 1'b0;
  endtask

  // Drives one response beat with the same handshake.
  task automatic send_d(input logic [2:0] op, input logic [1:0] param,
                        input logic [`TL_SIZE_WIDTH-1:0] size,
                        input logic [`TL_SOURCE_WIDTH-1:0] src,
                        input logic denied, input logic corrupt);
    int unsigned tries;
    logic rdy;
    tries = 0;
    {d_opcode, d_param, d_size, d_source, d_denied, d_corrupt} <=
        {op, param, size, src, denied, corrupt};
    d_valid <= 1'b1;
    do begin
      rdy = stall_en ? 1'($urandom_range(0, 1)) : 1'b1;
      d_ready <= rdy;
      @(posedge clk_i);
      tries++;
      if (tries > WaitLimit) abort_run("response beat was never accepted");
    end while (!rdy);
    d_valid <= 1'b0;
  endtask

  task automatic reset_dut();
    rst_ni <= 1'b0;
    repeat (10) @(posedge clk_i);
    rst_ni <= 1'b1;
    @(posedge clk_i);
  endtask

  initial begin
    errors = 0;
    stall_en = 1'b1;
    void'($urandom(32'he171_6213));
    clk_i = 1'b0;
    rst_ni = 1'b0;
    {a_valid, a_ready, a_opcode, a_param, a_size, a_source, a_address, a_mask, a_corrupt} = '0;
    {d_valid, d_ready, d_opcode, d_param, d_size, d_source, d_denied, d_corrupt} = '0;
    repeat (10) @(posedge clk_i);
    rst_ni <= 1'b1;
    @(posedge clk_i);

    // Legal traffic answered out of order.
    send_a(tl_mon_pkg::PutFullData, 0, 2, 1, 32'h100, 4'hf, 0);
    send_a(tl_mon_pkg::Get, 0, 1, 2, 32'h202, 4'hc, 0);
    send_a(tl_mon_pkg::PutPartialData, 0, 2, 3, 32'h300, 4'h5, 0);
    send_d(tl_mon_pkg::AccessAckData, 0, 1, 2, 0, 0);
    send_d(tl_mon_pkg::AccessAck, 0, 2, 3, 0, 0);
    send_d(tl_mon_pkg::AccessAck, 0, 2, 1, 0, 0);
    @(negedge clk_i);
    assert (!viol_sticky) else begin
      errors++;
      $display("[FAIL] %0t viol_sticky expected %b actual %b", $time, 1'b0, viol_sticky);
    end
    @(posedge clk_i);

    // Illegal requests that break one rule each.
    send_a(3'd2, 0, 2, 0, 32'h0, 4'hf, 0);
    send_a(tl_mon_pkg::Get, 3, 2, 0, 32'h0, 4'hf, 0);
    send_a(tl_mon_pkg::PutPartialData, 0, 3, 1, 32'h0, 4'hf, 0);
    send_a(tl_mon_pkg::PutFullData, 0, 2, 2, 32'h0, 4'h7, 0);
    send_a(tl_mon_pkg::Get, 0, 2, 3, 32'h0, 4'hb, 0);
    send_a(tl_mon_pkg::Get, 0, 1, 4, 32'h1, 4'h6, 0);
    send_a(tl_mon_pkg::Get, 0, 2, 5, 32'h0, 4'hf, 1);

    // Busy source keeps the first request.
    send_a(tl_mon_pkg::Get, 0, 2, 6, 32'h60, 4'hf, 0);
    send_a(tl_mon_pkg::PutFullData, 0, 2, 6, 32'h64, 4'hf, 0);
    send_d(tl_mon_pkg::AccessAckData, 0, 2, 6, 0, 0);

    // Retire and reuse of one source in the same cycle.
    stall_en = 1'b0;
    send_a(tl_mon_pkg::PutFullData, 0, 2, 7, 32'h70, 4'hf, 0);
    fork
      send_d(tl_mon_pkg::AccessAck, 0, 2, 7, 0, 0);
      send_a(tl_mon_pkg::Get, 0, 2, 7, 32'h70, 4'hf, 0);
    join
    send_d(tl_mon_pkg::AccessAckData, 0, 2, 7, 0, 0);
    stall_en = 1'b1;

    // Bad responses against the entries left above.
    send_d(tl_mon_pkg::AccessAck, 0, 2, 6, 0, 0);
    send_d(3'd5, 0, 2, 0, 0, 0);
    send_d(tl_mon_pkg::AccessAck, 0, 2, 0, 0, 0);
    send_d(tl_mon_pkg::AccessAck, 0, 1, 2, 0, 0);
    send_d(tl_mon_pkg::AccessAckData, 1, 2, 3, 0, 0);
    send_d(tl_mon_pkg::AccessAckData, 0, 1, 4, 1, 0);
    send_d(tl_mon_pkg::AccessAck, 0, 3, 1, 0, 1);
    send_d(tl_mon_pkg::AccessAckData, 0, 2, 5, 1, 1);

    // Sticky clears only here.
    reset_dut();
    for (int n = 0; n < 400; n++) begin
      if ($urandom_range(0, 1) == 0) begin
        send_a($urandom_range(0, 7), ($urandom_range(0, 7) == 0), $urandom_range(0, 3),
               $urandom_range(0, 7), $urandom_range(0, 15), $urandom_range(0, 15),
               ($urandom_range(0, 9) == 0));
      end else begin
        send_d($urandom_range(0, 2), ($urandom_range(0, 7) == 0), $urandom_range(0, 3),
               $urandom_range(0, 7), ($urandom_range(0, 5) == 0), $urandom_range(0, 1));
      end
    end

    repeat (2) @(posedge clk_i);
    $display("checks failed: %0d, property failures: %0d", errors,
             tl_ul_monitor_inst.tl_ul_monitor_properties_inst.prop_fails);
    if (errors == 0 && tl_ul_monitor_inst.tl_ul_monitor_properties_inst.prop_fails == 0) begin
      $display("test passed");
    end else begin
      $display("test failed");
    end
    $finish;
  end

endmodule

// ==== filelist.f ====
+incdir+source
source/tl_mon_pkg.sv
source/tl_a_if.sv
source/tl_d_if.sv
source/tl_a_checker.sv
source/tl_pending_table.sv
source/tl_d_checker.sv
source/tl_ul_monitor.sv
verification/tl_ul_monitor_properties.sv
verification/tl_ul_monitor_tb.sv
